// ==== bpred_macros.svh ====
`ifndef BPRED_MACROS_SVH
`define BPRED_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Predictor sizing
////////////////////////////////////////////////////////////////////////////

// Fetch and resolve address width
`define BP_XLEN 32

// Direction table holds 2**BP_DIR_BITS two-bit counters
`define BP_DIR_BITS 6

// Direct-mapped BTB holds 2**BP_BTB_BITS entries
`define BP_BTB_BITS 4

// Return address stack entries
`define BP_RAS_DEPTH 8

// Accuracy counter width
`define BP_CNT_BITS 16

`endif

// ==== bpredPkg.sv ====
`default_nettype none

`include "bpred_macros.svh"

package bpredPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction class
  ////////////////////////////////////////////////////////////////////////////

  // Decoded control-flow class, shared by BTB entries and the resolve bus
  typedef enum logic [2:0] {
    classNone   = 3'd0,
    classBranch = 3'd1,
    classJump   = 3'd2,
    classCall   = 3'd3,
    classReturn = 3'd4
  } bpClassE;

  ////////////////////////////////////////////////////////////////////////////
  // One fetch-side prediction
  ////////////////////////////////////////////////////////////////////////////

  // Held in the output register until the consumer takes it
  typedef struct packed {
    // Predicted next fetch address
    logic [`BP_XLEN-1:0] nextPc;
    // Class taken from the BTB, classNone on a miss
    bpClassE             cls;
    // High whenever nextPc is not the fall-through
    logic                taken;
  } bpPredT;

endpackage

`default_nettype wire

// ==== bpResolveIf.sv ====
`default_nettype none

`include "bpred_macros.svh"

interface bpResolveIf import bpredPkg::*; ();

  // One resolved control-flow instruction from execute
  logic                valid;
  logic [`BP_XLEN-1:0] pc;
  bpClassE             cls;
  logic                taken;
  logic [`BP_XLEN-1:0] target;
  // Address the predictor gave after this instruction
  logic [`BP_XLEN-1:0] predPc;
  logic                predTaken;

  // Driven once at the top level
  modport src (
    output valid, pc, cls, taken, target, predPc, predTaken
  );

  // Every table and the checker listen, no back-pressure
  modport sink (
    input valid, pc, cls, taken, target, predPc, predTaken
  );

endinterface

`default_nettype wire

// ==== dirPredictor.sv ====
`default_nettype none

`include "bpred_macros.svh"

module dirPredictor import bpredPkg::*; (
  input  logic                clk,
  input  logic                arstN,
  input  logic [`BP_XLEN-1:0] lookupPc,
  output logic                predTaken,
  bpResolveIf.sink            rsv
);

  localparam int IdxW    = `BP_DIR_BITS;
  localparam int Entries = 1 << IdxW;

  // Two-bit saturating counters, 0..1 not taken, 2..3 taken
  logic [1:0]      ctr [Entries];
  logic [IdxW-1:0] lookIdx;
  logic [IdxW-1:0] updIdx;
  logic [1:0]      updCtr;
  logic            updEn;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////

  // Word index, bits 1:0 are always zero without compressed code
  assign lookIdx = lookupPc[IdxW+1:2];

  // MSB of the counter is the direction
  assign predTaken = ctr[lookIdx][1];

  ////////////////////////////////////////////////////////////////////////////
  // Update
  ////////////////////////////////////////////////////////////////////////////

  assign updIdx = rsv.pc[IdxW+1:2];
  assign updCtr = ctr[updIdx];
  // Only conditional branches train the direction table
  assign updEn  = rsv.valid && (rsv.cls == classBranch);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      // Weakly not taken
      for (int i = 0; i < Entries; i++) begin
        ctr[i] <= 2'd1;
      end
    end else if (updEn) begin
      if (rsv.taken) begin
        // Saturate at strongly taken
        if (updCtr != 2'd3) begin
          ctr[updIdx] <= updCtr + 2'd1;
        end
      end else begin
        // Saturate at strongly not taken
        if (updCtr != 2'd0) begin
          ctr[updIdx] <= updCtr - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== targetBuffer.sv ====
`default_nettype none

`include "bpred_macros.svh"

module targetBuffer import bpredPkg::*; (
  input  logic                clk,
  input  logic                arstN,
  input  logic [`BP_XLEN-1:0] lookupPc,
  output logic                hit,
  output bpClassE             hitClass,
  output logic [`BP_XLEN-1:0] hitTarget,
  bpResolveIf.sink            rsv
);

  localparam int IdxW    = `BP_BTB_BITS;
  localparam int Entries = 1 << IdxW;
  // Tag covers every PC bit above the index
  localparam int TagW    = `BP_XLEN - IdxW - 2;

  // Valid bits are control state and the rest is payload
  logic                entValid  [Entries];
  logic [TagW-1:0]     entTag    [Entries];
  bpClassE             entClass  [Entries];
  logic [`BP_XLEN-1:0] entTarget [Entries];

  logic [IdxW-1:0]     lookIdx;
  logic [TagW-1:0]     lookTag;
  logic [IdxW-1:0]     updIdx;
  logic [TagW-1:0]     updTag;
  logic                updWrite;
  logic                updKill;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////

  assign lookIdx = lookupPc[IdxW+1:2];
  assign lookTag = lookupPc[`BP_XLEN-1:IdxW+2];

  assign hit       = entValid[lookIdx] && (entTag[lookIdx] == lookTag);
  // Entry fields read out raw and the top level qualifies them with hit
  assign hitClass  = entClass[lookIdx];
  assign hitTarget = entTarget[lookIdx];

  ////////////////////////////////////////////////////////////////////////////
  // Update
  ////////////////////////////////////////////////////////////////////////////

  assign updIdx = rsv.pc[IdxW+1:2];
  assign updTag = rsv.pc[`BP_XLEN-1:IdxW+2];

  // Any control-flow resolve allocates or refreshes its slot
  assign updWrite = rsv.valid && (rsv.cls != classNone);
  // Plain instruction that hit drops the stale class prediction
  assign updKill  = rsv.valid && (rsv.cls == classNone) &&
                    entValid[updIdx] && (entTag[updIdx] == updTag);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < Entries; i++) begin
        entValid[i] <= 1'b0;
      end
    end else if (updWrite) begin
      entValid[updIdx] <= 1'b1;
    end else if (updKill) begin
      entValid[updIdx] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (updWrite) begin
      entTag[updIdx]    <= updTag;
      entClass[updIdx]  <= rsv.cls;
      entTarget[updIdx] <= rsv.target;
    end
  end

endmodule

`default_nettype wire

// ==== returnStack.sv ====
`default_nettype none

`include "bpred_macros.svh"

module returnStack import bpredPkg::*; (
  input  logic                clk,
  input  logic                arstN,
  output logic [`BP_XLEN-1:0] top,
  output logic                empty,
  bpResolveIf.sink            rsv
);

  localparam int Depth = `BP_RAS_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);

  logic [`BP_XLEN-1:0] stack [Depth];
  // Next free slot, wraps onto the oldest entry when full
  logic [PtrW-1:0]     wrPtr;
  logic [PtrW-1:0]     topPtr;
  logic [PtrW-1:0]     incPtr;
  logic [CntW-1:0]     count;
  logic                doPush;
  logic                doPop;

  ////////////////////////////////////////////////////////////////////////////
  // Pointer arithmetic
  ////////////////////////////////////////////////////////////////////////////

  // Explicit wrap so a non power of two depth still works
  assign incPtr = (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
  assign topPtr = (wrPtr == '0) ? PtrW'(Depth - 1) : wrPtr - 1'b1;

  assign empty = (count == '0);
  assign top   = stack[topPtr];

  assign doPush = rsv.valid && (rsv.cls == classCall);
  // Return on an empty stack leaves it alone
  assign doPop  = rsv.valid && (rsv.cls == classReturn) && !empty;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      count <= '0;
    end else if (doPush) begin
      wrPtr <= incPtr;
      // Count sticks at depth, the oldest link is lost
      if (count != CntW'(Depth)) begin
        count <= count + 1'b1;
      end
    end else if (doPop) begin
      wrPtr <= topPtr;
      count <= count - 1'b1;
    end
  end

  // Link address is the fall-through of the call
  always_ff @(posedge clk) begin
    if (doPush) begin
      stack[wrPtr] <= rsv.pc + `BP_XLEN'(4);
    end
  end

endmodule

`default_nettype wire

// ==== predictCheck.sv ====
`default_nettype none

`include "bpred_macros.svh"

module predictCheck import bpredPkg::*; (
  input  logic                   clk,
  input  logic                   arstN,
  bpResolveIf.sink               rsv,
  output logic                   mispredict,
  output logic [`BP_XLEN-1:0]    correctPc,
  output logic [`BP_CNT_BITS-1:0] mispredictCount,
  output logic [`BP_CNT_BITS-1:0] dirWrongCount,
  output logic [`BP_CNT_BITS-1:0] targetWrongCount
);

  logic [`BP_XLEN-1:0] actualPc;
  logic                pcWrong;
  logic                dirWrong;
  logic                targetWrong;

  // Where fetch should have gone after this instruction
  assign actualPc = rsv.taken ? rsv.target : rsv.pc + `BP_XLEN'(4);

  assign pcWrong     = rsv.valid && (actualPc != rsv.predPc);
  // Direction only matters for conditional branches
  assign dirWrong    = rsv.valid && (rsv.cls == classBranch) && (rsv.predTaken != rsv.taken);
  // Taken control flow that went somewhere other than its target
  assign targetWrong = rsv.valid && rsv.taken && (rsv.cls != classNone) &&
                       (rsv.predPc != rsv.target);

  ////////////////////////////////////////////////////////////////////////////
  // Registered flag, corrected PC and accuracy counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mispredict       <= 1'b0;
      mispredictCount  <= '0;
      dirWrongCount    <= '0;
      targetWrongCount <= '0;
    end else begin
      mispredict <= pcWrong;
      if (pcWrong) begin
        mispredictCount <= mispredictCount + 1'b1;
      end
      if (dirWrong) begin
        dirWrongCount <= dirWrongCount + 1'b1;
      end
      if (targetWrong) begin
        targetWrongCount <= targetWrongCount + 1'b1;
      end
    end
  end

  // Meaningful only alongside mispredict
  always_ff @(posedge clk) begin
    if (rsv.valid) begin
      correctPc <= actualPc;
    end
  end

endmodule

`default_nettype wire

// ==== bpredTop.sv ====
`default_nettype none

`include "bpred_macros.svh"

module bpredTop import bpredPkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  // Fetch request
  input  logic                    fetchValid,
  input  logic [`BP_XLEN-1:0]     fetchPc,
  output logic                    fetchReady,
  // Prediction out, one cycle after the fetch transfer
  output logic                    predValid,
  input  logic                    predReady,
  output logic [`BP_XLEN-1:0]     predNextPc,
  output bpClassE                 predClass,
  output logic                    predTaken,
  // Execute-stage resolve, accepted every valid cycle
  input  logic                    resolveValid,
  input  logic [`BP_XLEN-1:0]     resolvePc,
  input  bpClassE                 resolveClass,
  input  logic                    resolveTaken,
  input  logic [`BP_XLEN-1:0]     resolveTarget,
  input  logic [`BP_XLEN-1:0]     resolvePredPc,
  input  logic                    resolvePredTaken,
  // Correction and accuracy
  output logic                    mispredict,
  output logic [`BP_XLEN-1:0]     correctPc,
  output logic [`BP_CNT_BITS-1:0] mispredictCount,
  output logic [`BP_CNT_BITS-1:0] dirWrongCount,
  output logic [`BP_CNT_BITS-1:0] targetWrongCount
);

  bpResolveIf rsvIf ();

  logic                dirTaken;
  logic                btbHit;
  bpClassE             btbClass;
  logic [`BP_XLEN-1:0] btbTarget;
  logic [`BP_XLEN-1:0] rasTop;
  logic                rasEmpty;
  logic [`BP_XLEN-1:0] pcPlus4;
  bpPredT              predD;
  bpPredT              predQ;
  logic                fetchXfer;

  // Top level plays the src side of the resolve bus
  assign rsvIf.valid     = resolveValid;
  assign rsvIf.pc        = resolvePc;
  assign rsvIf.cls       = resolveClass;
  assign rsvIf.taken     = resolveTaken;
  assign rsvIf.target    = resolveTarget;
  assign rsvIf.predPc    = resolvePredPc;
  assign rsvIf.predTaken = resolvePredTaken;

  ////////////////////////////////////////////////////////////////////////////
  // Prediction structures
  ////////////////////////////////////////////////////////////////////////////

  dirPredictor uDir (.clk, .arstN, .lookupPc(fetchPc), .predTaken(dirTaken), .rsv(rsvIf));

  targetBuffer uBtb (
    .clk, .arstN, .lookupPc(fetchPc),
    .hit(btbHit), .hitClass(btbClass), .hitTarget(btbTarget), .rsv(rsvIf)
  );

  returnStack uRas (.clk, .arstN, .top(rasTop), .empty(rasEmpty), .rsv(rsvIf));

  predictCheck uChk (
    .clk, .arstN, .rsv(rsvIf), .mispredict, .correctPc,
    .mispredictCount, .dirWrongCount, .targetWrongCount
  );

  ////////////////////////////////////////////////////////////////////////////
  // Next-PC selection
  ////////////////////////////////////////////////////////////////////////////

  assign pcPlus4 = fetchPc + `BP_XLEN'(4);

  // Class comes from the BTB, a miss reads as classNone
  always_comb begin
    predD.cls    = btbHit ? btbClass : classNone;
    predD.nextPc = pcPlus4;
    case (predD.cls)
      classBranch: predD.nextPc = dirTaken ? btbTarget : pcPlus4;
      classJump,
      classCall:   predD.nextPc = btbTarget;
      classReturn: predD.nextPc = rasEmpty ? pcPlus4 : rasTop;
      default:     predD.nextPc = pcPlus4;
    endcase
    predD.taken = (predD.nextPc != pcPlus4);
  end

  // One-entry output register, refilled in the cycle it drains
  assign fetchReady = !predValid || predReady;
  assign fetchXfer  = fetchValid && fetchReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      predValid <= 1'b0;
    end else if (fetchReady) begin
      predValid <= fetchValid;
    end
  end

  always_ff @(posedge clk) begin
    if (fetchXfer) begin
      predQ <= predD;
    end
  end

  assign predNextPc = predQ.nextPc;
  assign predClass  = predQ.cls;
  assign predTaken  = predQ.taken;

endmodule

`default_nettype wire

// ==== bpredModel.svh ====
`ifndef BPRED_MODEL_SVH
`define BPRED_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model of all predictor state
////////////////////////////////////////////////////////////////////////////

// Direction counters, 0..1 not taken, 2..3 taken
logic [1:0]          mCtr       [1 << `BP_DIR_BITS];
// BTB keeps the whole PC instead of a tag
logic                mBtbValid  [1 << `BP_BTB_BITS];
logic [`BP_XLEN-1:0] mBtbPc     [1 << `BP_BTB_BITS];
bpClassE             mBtbClass  [1 << `BP_BTB_BITS];
logic [`BP_XLEN-1:0] mBtbTarget [1 << `BP_BTB_BITS];
// RAS as a queue, newest link at the back
logic [`BP_XLEN-1:0] mRas [$];
int                  mMisCnt;
int                  mDirCnt;
int                  mTgtCnt;

function automatic void modelReset();
  for (int i = 0; i < (1 << `BP_DIR_BITS); i++) begin
    mCtr[i] = 2'd1;
  end
  for (int i = 0; i < (1 << `BP_BTB_BITS); i++) begin
    mBtbValid[i] = 1'b0;
  end
  mRas.delete();
  mMisCnt = 0;
  mDirCnt = 0;
  mTgtCnt = 0;
endfunction

function automatic int dirIndex(input logic [`BP_XLEN-1:0] pc);
  return int'((pc >> 2) & ((1 << `BP_DIR_BITS) - 1));
endfunction

function automatic int btbIndex(input logic [`BP_XLEN-1:0] pc);
  return int'((pc >> 2) & ((1 << `BP_BTB_BITS) - 1));
endfunction

// Prediction from the state as it stands, before any same-cycle resolve
function automatic bpPredT modelPredict(input logic [`BP_XLEN-1:0] pc);
  bpPredT p;
  int     b;
  b        = btbIndex(pc);
  p.cls    = classNone;
  p.nextPc = pc + 32'd4;
  if (mBtbValid[b] && (mBtbPc[b] == pc)) begin
    p.cls = mBtbClass[b];
    case (p.cls)
      classBranch: if (mCtr[dirIndex(pc)] >= 2'd2) p.nextPc = mBtbTarget[b];
      classJump:   p.nextPc = mBtbTarget[b];
      classCall:   p.nextPc = mBtbTarget[b];
      classReturn: if (mRas.size() > 0) p.nextPc = mRas[$];
      default:     p.nextPc = pc + 32'd4;
    endcase
  end
  p.taken = (p.nextPc != pc + 32'd4);
  return p;
endfunction

// Applies one resolve and returns the expected correction
function automatic void modelResolve(
  input  logic [`BP_XLEN-1:0] pc,
  input  bpClassE             cls,
  input  logic                taken,
  input  logic [`BP_XLEN-1:0] target,
  input  logic [`BP_XLEN-1:0] predPc,
  input  logic                predTaken,
  output logic                expMis,
  output logic [`BP_XLEN-1:0] expPc
);
  int d;
  int b;
  d      = dirIndex(pc);
  b      = btbIndex(pc);
  expPc  = taken ? target : pc + 32'd4;
  expMis = (expPc != predPc);
  if (expMis) mMisCnt++;
  if ((cls == classBranch) && (predTaken != taken)) mDirCnt++;
  if (taken && (cls != classNone) && (predPc != target)) mTgtCnt++;
  if (cls == classBranch) begin
    if (taken && (mCtr[d] != 2'd3)) mCtr[d] = mCtr[d] + 2'd1;
    if (!taken && (mCtr[d] != 2'd0)) mCtr[d] = mCtr[d] - 2'd1;
  end
  if (cls != classNone) begin
    mBtbValid[b]  = 1'b1;
    mBtbPc[b]     = pc;
    mBtbClass[b]  = cls;
    mBtbTarget[b] = target;
  end else if (mBtbValid[b] && (mBtbPc[b] == pc)) begin
    mBtbValid[b] = 1'b0;
  end
  // Oldest link falls off the front once the stack is over depth
  if (cls == classCall) begin
    mRas.push_back(pc + 32'd4);
    if (mRas.size() > `BP_RAS_DEPTH) void'(mRas.pop_front());
  end
  if ((cls == classReturn) && (mRas.size() > 0)) void'(mRas.pop_back());
endfunction

`endif

// ==== bpredTb.sv ====
`default_nettype none

`include "bpred_macros.svh"

module bpredTb import bpredPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RandOps       = 400;
  localparam int DirectedOps   = 45;
  localparam int NumOps        = RandOps + DirectedOps;
  localparam int TimeoutCycles = 20 * NumOps;

  logic                    clk = 1'b0;
  logic                    arstN;
  logic                    fetchValid;
  logic [`BP_XLEN-1:0]     fetchPc;
  logic                    fetchReady;
  logic                    predValid;
  logic                    predReady;
  logic [`BP_XLEN-1:0]     predNextPc;
  bpClassE                 predClass;
  logic                    predTaken;
  logic                    resolveValid;
  logic [`BP_XLEN-1:0]     resolvePc;
  bpClassE                 resolveClass;
  logic                    resolveTaken;
  logic [`BP_XLEN-1:0]     resolveTarget;
  logic [`BP_XLEN-1:0]     resolvePredPc;
  logic                    resolvePredTaken;
  logic                    mispredict;
  logic [`BP_XLEN-1:0]     correctPc;
  logic [`BP_CNT_BITS-1:0] mispredictCount;
  logic [`BP_CNT_BITS-1:0] dirWrongCount;
  logic [`BP_CNT_BITS-1:0] targetWrongCount;

  // Scoreboard holds at most one prediction in flight
  bpPredT              expQ [$];
  logic                expMis = 1'b0;
  logic [`BP_XLEN-1:0] expCorrect;
  logic                lastXfer;
  logic                fetchHeld;
  integer              seed;
  int                  cycles = 0;
  int                  errors = 0;

  `include "bpredModel.svh"

  bpredTop dut (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic reportError(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "stopping at first mismatch");
  endtask

  function automatic logic [`BP_XLEN-1:0] pickPc();
    logic [31:0] r;
    r = $random(seed);
    // 32 PCs where pairs share a BTB slot with different tags
    return 32'h1000 + (r[4] ? 32'h400 : 32'h0) + 32'({r[3:0], 2'b00});
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Output checks sampled mid cycle
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkOutputs();
    assert (expQ.size() == (predValid ? 1 : 0))
      else reportError($sformatf("predValid %0b with %0d predictions owed",
                                 predValid, expQ.size()));
    if (predValid) begin
      assert ((predNextPc == expQ[0].nextPc) && (predClass == expQ[0].cls) &&
              (predTaken == expQ[0].taken))
        else reportError($sformatf("prediction %h/%s/%0b, expected %h/%s/%0b",
                                   predNextPc, predClass.name(), predTaken, expQ[0].nextPc,
                                   expQ[0].cls.name(), expQ[0].taken));
    end
    // Ready follows the scoreboard's view of the output register
    assert (fetchReady == ((expQ.size() == 0) || predReady))
      else reportError($sformatf("fetchReady %0b with %0d owed and predReady %0b",
                                 fetchReady, expQ.size(), predReady));
    assert (mispredict == expMis)
      else reportError($sformatf("mispredict %0b, expected %0b", mispredict, expMis));
    if (expMis) begin
      assert (correctPc == expCorrect)
        else reportError($sformatf("correctPc %h, expected %h", correctPc, expCorrect));
    end
  endtask

  // One cycle drives after the edge, checks and then follows the handshakes
  task automatic step(
    input logic fV, input logic [31:0] fPc, input logic pR,
    input logic rV, input logic [31:0] rPc, input bpClassE rCls,
    input logic rTaken, input logic [31:0] rTarget, input logic [31:0] rPredPc
  );
    @(posedge clk);
    #1;
    fetchValid       = fV;
    fetchPc          = fPc;
    predReady        = pR;
    resolveValid     = rV;
    resolvePc        = rPc;
    resolveClass     = rCls;
    resolveTaken     = rTaken;
    resolveTarget    = rTarget;
    resolvePredPc    = rPredPc;
    resolvePredTaken = (rPredPc != rPc + 32'd4);
    #1;
    checkOutputs();
    if (predValid && predReady) void'(expQ.pop_front());
    lastXfer  = fetchValid && fetchReady;
    fetchHeld = fetchValid && !fetchReady;
    // Lookup sees the tables before this cycle's resolve
    if (lastXfer) expQ.push_back(modelPredict(fetchPc));
    if (resolveValid) begin
      modelResolve(resolvePc, resolveClass, resolveTaken, resolveTarget,
                   resolvePredPc, resolvePredTaken, expMis, expCorrect);
    end else begin
      expMis = 1'b0;
    end
  endtask

  task automatic idle();
    step(1'b0, 32'h0, 1'b1, 1'b0, 32'h0, classNone, 1'b0, 32'h0, 32'h0);
  endtask

  task automatic resolveOne(input logic [31:0] pc, input bpClassE cls, input logic taken,
                            input logic [31:0] target);
    step(1'b0, 32'h0, 1'b1, 1'b1, pc, cls, taken, target, pc + 32'd4);
  endtask

  // Fetches until accepted and compares the prediction with a fixed value
  task automatic expectNext(input logic [31:0] pc, input logic [31:0] nextPc,
                            input bpClassE cls);
    do begin
      step(1'b1, pc, 1'b1, 1'b0, 32'h0, classNone, 1'b0, 32'h0, 32'h0);
    end while (!lastXfer);
    do begin
      idle();
    end while (!predValid);
    assert ((predNextPc == nextPc) && (predClass == cls))
      else reportError($sformatf("fetch %h predicted %h/%s, expected %h/%s", pc,
                                 predNextPc, predClass.name(), nextPc, cls.name()));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic        fV;
    logic [31:0] fPc;
    logic [31:0] rPc;
    bpClassE     rCls;
    logic        rTaken;
    bpPredT      rPred;
    seed = 32'h3c99;
    arstN = 1'b0;
    fetchValid = 1'b0;
    fetchPc = '0;
    predReady = 1'b0;
    resolveValid = 1'b0;
    resolvePc = '0;
    resolveClass = classNone;
    resolveTaken = 1'b0;
    resolveTarget = '0;
    resolvePredPc = '0;
    resolvePredTaken = 1'b0;
    fV = 1'b0;
    fPc = '0;
    fetchHeld = 1'b0;
    modelReset();
    repeat (10) @(posedge clk);
    #1 arstN = 1'b1;

    // Branch trains up in two taken resolves and back in two not taken
    expectNext(32'h100, 32'h104, classNone);
    resolveOne(32'h100, classBranch, 1'b1, 32'h400);
    resolveOne(32'h100, classBranch, 1'b1, 32'h400);
    expectNext(32'h100, 32'h400, classBranch);
    resolveOne(32'h100, classBranch, 1'b0, 32'h400);
    expectNext(32'h100, 32'h400, classBranch);
    resolveOne(32'h100, classBranch, 1'b0, 32'h400);
    expectNext(32'h100, 32'h104, classBranch);

    // Return learned on an empty stack before ten calls wrap the RAS
    resolveOne(32'h300, classReturn, 1'b1, 32'h900);
    expectNext(32'h300, 32'h304, classReturn);
    for (int i = 0; i < 10; i++) begin
      resolveOne(32'h204 + 32'(8 * i), classCall, 1'b1, 32'h800);
    end
    // Only the newest eight links survive in LIFO order
    for (int i = 9; i >= 2; i--) begin
      expectNext(32'h300, 32'h208 + 32'(8 * i), classReturn);
      resolveOne(32'h300, classReturn, 1'b1, 32'h208 + 32'(8 * i));
    end
    expectNext(32'h300, 32'h304, classReturn);
    resolveOne(32'h300, classReturn, 1'b1, 32'h900);
    expectNext(32'h300, 32'h304, classReturn);

    // Plain instruction at a BTB hit drops the entry
    resolveOne(32'h140, classJump, 1'b1, 32'h600);
    expectNext(32'h140, 32'h600, classJump);
    resolveOne(32'h140, classNone, 1'b0, 32'h144);
    expectNext(32'h140, 32'h144, classNone);

    // Random traffic with back-pressure holds each fetch stable until taken
    for (int n = 0; n < RandOps; n++) begin
      r = $random(seed);
      if (!fetchHeld) begin
        fV  = r[0] | r[1];
        fPc = pickPc();
      end
      rPc    = pickPc();
      rCls   = bpClassE'(3'($unsigned($random(seed)) % 32'd5));
      rTaken = (rCls == classBranch) ? r[5] : (rCls != classNone);
      rPred  = modelPredict(rPc);
      step(fV, fPc, r[2] | r[3], r[4], rPc, rCls, rTaken, pickPc(),
           r[6] ? rPred.nextPc : pickPc());
    end
    idle();
    idle();

    assert ((mispredictCount == 16'(mMisCnt)) && (dirWrongCount == 16'(mDirCnt)) &&
            (targetWrongCount == 16'(mTgtCnt)))
      else reportError($sformatf("counters %0d/%0d/%0d, expected %0d/%0d/%0d",
                                 mispredictCount, dirWrongCount, targetWrongCount,
                                 mMisCnt, mDirCnt, mTgtCnt));

    if (errors == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "checks reported errors");
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
bpredPkg.sv
bpResolveIf.sv
dirPredictor.sv
targetBuffer.sv
returnStack.sv
predictCheck.sv
bpredTop.sv
bpredTb.sv

// ==== Makefile ====
# Verilator flow for the branch predictor testbench
VERILATOR ?= verilator
TOP       ?= bpredTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Result is decided by the pass line in the log
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
